// File: common/e100_cfg.svh
/*
 * Build-wide sizes for the E100 core.
 * Word width and address width must stay consistent with the memory model.
 * The reset IAR value has to fit in E100_ADDR_WIDTH bits.
 */
`ifndef E100_CFG_SVH
`define E100_CFG_SVH

// data and bus width
`define E100_WORD_WIDTH 32

// memory word address width
`define E100_ADDR_WIDTH 10

// address of the first instruction
`define E100_RESET_IAR 0

`endif

// File: common/e100_pkg.sv
/*
 * Types shared by the E100 core.
 * Only the opcodes that the core executes are listed here.
 * Any other opcode value is treated as halt by the control FSM.
 */
`include "e100_cfg.svh"

package e100_pkg;

    typedef logic [`E100_WORD_WIDTH-1:0] word_t;
    typedef logic [`E100_ADDR_WIDTH-1:0] addr_t;

    // encodings follow the E100 instruction set
    typedef enum logic [31:0] {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_not  = 32'd8,
        op_be   = 32'd13,
        op_bne  = 32'd14,
        op_blt  = 32'd15
    } opcode_e;

    typedef enum logic [7:0] {
        state_reset,
        state_fetch1, state_fetch2, state_fetch3, state_fetch4,
        state_fetch5, state_fetch6, state_fetch7, state_fetch8,
        state_decode,
        state_halt,
        state_alu1, state_alu2, state_alu3, state_alu4, state_alu5, state_alu6,
        state_not1, state_not2, state_not3, state_not4,
        state_cp1, state_cp2, state_cp3, state_cp4,
        state_br1, state_br2, state_br3, state_br4, state_br5, state_br6
    } state_e;

    // who drives the shared bus this cycle
    typedef enum logic [2:0] {
        bus_none, bus_iar, bus_plus1, bus_memory,
        bus_alu, bus_arg1, bus_arg2, bus_arg3
    } bus_src_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_not
    } alu_op_e;

endpackage

// File: rtl/e100_iar.sv
/*
 * Instruction address register.
 * Bus values wider than the address are truncated on load.
 */
`timescale 1ns/1ps
`include "e100_cfg.svh"

module e100_iar (
    input  logic            clock,
    input  logic            reset,
    input  logic            iar_write,
    input  e100_pkg::word_t bus,
    output e100_pkg::addr_t iar,
    output e100_pkg::word_t iar_plus1
);
    import e100_pkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            iar <= addr_t'(`E100_RESET_IAR);
        end else if (iar_write) begin
            iar <= addr_t'(bus);
        end
    end

    // zero extended, wraps when written back
    assign iar_plus1 = word_t'(iar) + word_t'(1);

endmodule

// File: rtl/e100_datapath.sv
/*
 * Instruction registers, memory address register and the bus multiplexer.
 * The bus is zero when no source is selected.
 */
`timescale 1ns/1ps

module e100_datapath (
    input  logic               clock,
    input  logic               reset,
    input  e100_pkg::bus_src_e bus_src,
    input  e100_pkg::addr_t    iar,
    input  e100_pkg::word_t    iar_plus1,
    input  e100_pkg::word_t    alu_result,
    input  e100_pkg::word_t    mem_read_data,
    input  logic               address_write,
    input  logic               opcode_write,
    input  logic               arg1_write,
    input  logic               arg2_write,
    input  logic               arg3_write,
    output e100_pkg::word_t    bus,
    output e100_pkg::opcode_e  opcode,
    output e100_pkg::addr_t    mem_address
);
    import e100_pkg::*;

    word_t arg1;
    word_t arg2;
    word_t arg3;

    always_comb begin
        case (bus_src)
            bus_iar:    bus = word_t'(iar);
            bus_plus1:  bus = iar_plus1;
            bus_memory: bus = mem_read_data;
            bus_alu:    bus = alu_result;
            bus_arg1:   bus = arg1;
            bus_arg2:   bus = arg2;
            bus_arg3:   bus = arg3;
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            opcode      <= op_halt;
            mem_address <= '0;
        end else begin
            if (opcode_write) begin
                opcode <= opcode_e'(bus);
            end
            // memory address keeps the low bits of the bus
            if (address_write) begin
                mem_address <= addr_t'(bus);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arg1_write) begin
            arg1 <= bus;
        end
        if (arg2_write) begin
            arg2 <= bus;
        end
        if (arg3_write) begin
            arg3 <= bus;
        end
    end

endmodule

// File: rtl/e100_alu.sv
/*
 * Operand registers and ALU for the E100 core.
 * add and sub wrap at the word width. less compares op1 and op2 as signed.
 * not uses op1 only.
 */
`timescale 1ns/1ps

module e100_alu (
    input  logic              clock,
    input  logic              reset,
    input  e100_pkg::word_t   bus,
    input  logic              op1_write,
    input  logic              op2_write,
    input  e100_pkg::alu_op_e alu_op,
    output e100_pkg::word_t   alu_result,
    output logic              equal,
    output logic              less
);
    import e100_pkg::*;

    word_t op1;
    word_t op2;

    always_ff @(posedge clock) begin
        if (reset) begin
            op1 <= '0;
            op2 <= '0;
        end else begin
            if (op1_write) begin
                op1 <= bus;
            end
            if (op2_write) begin
                op2 <= bus;
            end
        end
    end

    always_comb begin
        case (alu_op)
            alu_sub: alu_result = op1 - op2;
            alu_and: alu_result = op1 & op2;
            alu_or:  alu_result = op1 | op2;
            alu_not: alu_result = ~op1;
            default: alu_result = op1 + op2;
        endcase
    end

    // branch flags
    assign equal = (op1 == op2);
    assign less  = ($signed(op1) < $signed(op2));

endmodule

// File: control/e100_control.sv
/*
 * E100 control FSM. Every state lasts exactly one cycle.
 * add, sub, and, or share one sequence, and the three branches share another.
 * Opcodes outside the supported set go to halt, which holds until reset.
 */
`timescale 1ns/1ps

module e100_control (
    input  logic               clock,
    input  logic               reset,
    input  e100_pkg::opcode_e  opcode,
    input  logic               equal,
    input  logic               less,
    output e100_pkg::bus_src_e bus_src,
    output e100_pkg::alu_op_e  alu_op,
    output logic               iar_write,
    output logic               address_write,
    output logic               opcode_write,
    output logic               arg1_write,
    output logic               arg2_write,
    output logic               arg3_write,
    output logic               op1_write,
    output logic               op2_write,
    output logic               mem_write,
    output logic               halted
);
    import e100_pkg::*;

    state_e  state;
    state_e  next_state;
    opcode_e branch_op;
    logic    branch_taken;

    always_comb begin
        case (branch_op)
            op_be:   branch_taken = equal;
            op_bne:  branch_taken = !equal;
            op_blt:  branch_taken = less;
            default: branch_taken = 1'b0;
        endcase
    end

    // bus source and write strobes per state
    always_comb begin
        bus_src       = bus_none;
        iar_write     = 1'b0;
        address_write = 1'b0;
        opcode_write  = 1'b0;
        arg1_write    = 1'b0;
        arg2_write    = 1'b0;
        arg3_write    = 1'b0;
        op1_write     = 1'b0;
        op2_write     = 1'b0;
        mem_write     = 1'b0;
        case (state)
            state_fetch1: begin
                bus_src       = bus_iar;
                address_write = 1'b1;
            end
            state_fetch3, state_fetch5, state_fetch7: begin
                // step to the next word of the instruction
                bus_src       = bus_plus1;
                iar_write     = 1'b1;
                address_write = 1'b1;
            end
            state_fetch2: begin
                bus_src      = bus_memory;
                opcode_write = 1'b1;
            end
            state_fetch4: begin
                bus_src    = bus_memory;
                arg1_write = 1'b1;
            end
            state_fetch6: begin
                bus_src    = bus_memory;
                arg2_write = 1'b1;
            end
            state_fetch8, state_cp2: begin
                // cp parks mem[arg2] in arg3
                bus_src    = bus_memory;
                arg3_write = 1'b1;
            end
            state_decode: begin
                // iar now points at the following instruction
                bus_src   = bus_plus1;
                iar_write = 1'b1;
            end
            state_alu1, state_not1, state_cp1, state_br1: begin
                bus_src       = bus_arg2;
                address_write = 1'b1;
            end
            state_alu2, state_not2, state_br2: begin
                bus_src   = bus_memory;
                op1_write = 1'b1;
            end
            state_alu3, state_br3: begin
                bus_src       = bus_arg3;
                address_write = 1'b1;
            end
            state_alu4, state_br4: begin
                bus_src   = bus_memory;
                op2_write = 1'b1;
            end
            state_alu5, state_not3, state_cp3: begin
                bus_src       = bus_arg1;
                address_write = 1'b1;
            end
            state_alu6, state_not4: begin
                bus_src   = bus_alu;
                mem_write = 1'b1;
            end
            state_cp4: begin
                bus_src   = bus_arg3;
                mem_write = 1'b1;
            end
            state_br6: begin
                // taken branch, jump to arg1
                bus_src   = bus_arg1;
                iar_write = 1'b1;
            end
            default: begin
                bus_src = bus_none;
            end
        endcase
    end

    always_comb begin
        next_state = state_fetch1;
        case (state)
            state_fetch1: next_state = state_fetch2;
            state_fetch2: next_state = state_fetch3;
            state_fetch3: next_state = state_fetch4;
            state_fetch4: next_state = state_fetch5;
            state_fetch5: next_state = state_fetch6;
            state_fetch6: next_state = state_fetch7;
            state_fetch7: next_state = state_fetch8;
            state_fetch8: next_state = state_decode;
            state_decode: begin
                case (opcode)
                    op_add, op_sub, op_and, op_or: next_state = state_alu1;
                    op_not:                        next_state = state_not1;
                    op_cp:                         next_state = state_cp1;
                    op_be, op_bne, op_blt:         next_state = state_br1;
                    default:                       next_state = state_halt;
                endcase
            end
            state_halt: next_state = state_halt;
            state_alu1: next_state = state_alu2;
            state_alu2: next_state = state_alu3;
            state_alu3: next_state = state_alu4;
            state_alu4: next_state = state_alu5;
            state_alu5: next_state = state_alu6;
            state_not1: next_state = state_not2;
            state_not2: next_state = state_not3;
            state_not3: next_state = state_not4;
            state_cp1:  next_state = state_cp2;
            state_cp2:  next_state = state_cp3;
            state_cp3:  next_state = state_cp4;
            state_br1:  next_state = state_br2;
            state_br2:  next_state = state_br3;
            state_br3:  next_state = state_br4;
            state_br4:  next_state = state_br5;
            state_br5:  next_state = branch_taken ? state_br6 : state_fetch1;
            default:    next_state = state_fetch1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= state_reset;
            alu_op    <= alu_add;
            branch_op <= op_halt;
        end else begin
            state <= next_state;
            if (state == state_decode) begin
                // remember the operation for the shared sequences
                branch_op <= opcode;
                case (opcode)
                    op_sub:  alu_op <= alu_sub;
                    op_and:  alu_op <= alu_and;
                    op_or:   alu_op <= alu_or;
                    op_not:  alu_op <= alu_not;
                    default: alu_op <= alu_add;
                endcase
            end
        end
    end

    assign halted = (state == state_halt);

endmodule

// File: rtl/e100_core.sv
/*
 * E100 multicycle core, one instruction in flight.
 * Memory is external with a combinational read and a write on the rising clock.
 * Unknown opcodes halt the core until the next reset.
 */
`timescale 1ns/1ps

module e100_core (
    input  logic             clock,
    input  logic             reset,
    output e100_pkg::addr_t  mem_address,
    input  e100_pkg::word_t  mem_read_data,
    output e100_pkg::word_t  mem_write_data,
    output logic             mem_write,
    output logic             halted
);
    import e100_pkg::*;

    word_t    bus;
    word_t    iar_plus1;
    word_t    alu_result;
    addr_t    iar;
    opcode_e  opcode;
    bus_src_e bus_src;
    alu_op_e  alu_op;
    logic     equal;
    logic     less;
    logic     iar_write;
    logic     address_write;
    logic     opcode_write;
    logic     arg1_write;
    logic     arg2_write;
    logic     arg3_write;
    logic     op1_write;
    logic     op2_write;

    // memory always sees the bus as write data
    assign mem_write_data = bus;

    e100_control u_control (
        .clock(clock), .reset(reset), .opcode(opcode), .equal(equal), .less(less),
        .bus_src(bus_src), .alu_op(alu_op), .iar_write(iar_write),
        .address_write(address_write), .opcode_write(opcode_write),
        .arg1_write(arg1_write), .arg2_write(arg2_write), .arg3_write(arg3_write),
        .op1_write(op1_write), .op2_write(op2_write),
        .mem_write(mem_write), .halted(halted)
    );

    e100_iar u_iar (
        .clock(clock), .reset(reset), .iar_write(iar_write), .bus(bus),
        .iar(iar), .iar_plus1(iar_plus1)
    );

    e100_datapath u_datapath (
        .clock(clock), .reset(reset), .bus_src(bus_src), .iar(iar),
        .iar_plus1(iar_plus1), .alu_result(alu_result), .mem_read_data(mem_read_data),
        .address_write(address_write), .opcode_write(opcode_write),
        .arg1_write(arg1_write), .arg2_write(arg2_write), .arg3_write(arg3_write),
        .bus(bus), .opcode(opcode), .mem_address(mem_address)
    );

    e100_alu u_alu (
        .clock(clock), .reset(reset), .bus(bus), .op1_write(op1_write),
        .op2_write(op2_write), .alu_op(alu_op), .alu_result(alu_result),
        .equal(equal), .less(less)
    );

endmodule

// File: tb/e100_asserts.sv
/*
 * Protocol checks bound into the E100 core.
 * Sampled on the rising clock, halt checks are disabled during reset.
 */
`timescale 1ns/1ps

module e100_asserts (
    input logic clock,
    input logic reset,
    input logic mem_write,
    input logic halted
);

    // number of failed checks so far
    int unsigned failures = 0;

    // no memory write while reset is held
    no_write_in_reset: assert property (@(posedge clock) reset |-> !mem_write)
        else begin
            $error("memory write while reset is high");
            failures++;
        end

    // halt is left only through reset
    halt_holds: assert property (@(posedge clock) disable iff (reset) halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            failures++;
        end

    no_write_in_halt: assert property (@(posedge clock) !(mem_write && halted))
        else begin
            $error("memory write while the core is halted");
            failures++;
        end

endmodule

// File: tb/e100_tb.sv
/*
 * Testbench for the E100 core with a word-array memory model.
 * Each table row runs one instruction, then a fixed tail of two cp and a halt.
 * The cp at 4 overwrites the source of the cp at 8, so cell 100 ends at 1
 * after a fall-through and at 2 after a jump straight to 8.
 */
`timescale 1ns/1ps
`include "e100_cfg.svh"

module e100_tb;
    import e100_pkg::*;

    localparam int num_rows    = 17;
    localparam int reset_loops = 16;
    localparam int row_cycles  = 60;
    localparam int mem_words   = 1 << `E100_ADDR_WIDTH;
    localparam time watchdog_ns = num_rows * (row_cycles + reset_loops) * 20;

    typedef struct packed {
        word_t opcode;
        word_t arg1;
        word_t arg2;
        word_t arg3;
        word_t val2;
        word_t val3;
        word_t check_addr;
        word_t result;
        word_t cell100;
        word_t writes;
    } row_t;

    logic  clock;
    logic  reset;
    addr_t mem_address;
    word_t mem_read_data;
    word_t mem_write_data;
    logic  mem_write;
    logic  halted;
    word_t mem [0:mem_words-1];
    int    write_count;
    row_t  rows [0:num_rows-1];

    e100_core u_dut (
        .clock(clock), .reset(reset), .mem_address(mem_address),
        .mem_read_data(mem_read_data), .mem_write_data(mem_write_data),
        .mem_write(mem_write), .halted(halted)
    );

    bind e100_core e100_asserts u_asserts (
        .clock(clock), .reset(reset), .mem_write(mem_write), .halted(halted)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // combinational read, write on the rising edge
    assign mem_read_data = mem[mem_address];
    always @(posedge clock) begin
        if (mem_write) begin
            mem[mem_address] <= mem_write_data;
            write_count = write_count + 1;
        end
    end

    // data rows write to 40 from 41 and 42, then the tail runs
    function automatic row_t data_row(word_t code, word_t a, word_t b, word_t res);
        return '{code, 32'd40, 32'd41, 32'd42, a, b, 32'd40, res, 32'd1, 32'd3};
    endfunction

    // branch target is 8, cell 201 shows which path was taken
    function automatic row_t branch_row(word_t code, word_t a, word_t b, logic taken);
        word_t marker;
        marker = taken ? 32'd2 : 32'd1;
        return '{code, 32'd8, 32'd41, 32'd42, a, b, 32'd201, marker, marker,
                 taken ? 32'd1 : 32'd2};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t want);
        assert (got === want)
        else abort_run($sformatf("MISMATCH time=%0t %s got 0x%08h expected 0x%08h",
                                 $time, name, got, want));
    endtask

    // a failed protocol assertion in the core ends the run
    always @(u_dut.u_asserts.failures) begin
        assert (u_dut.u_asserts.failures == 0)
        else abort_run("a protocol assertion inside the core failed");
    end

    task automatic load_program(input row_t r);
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = '0;
        end
        write_count = 0;
        mem[0] = r.opcode;
        mem[1] = r.arg1;
        mem[2] = r.arg2;
        mem[3] = r.arg3;
        mem[addr_t'(r.arg2)] = r.val2;
        mem[addr_t'(r.arg3)] = r.val3;
        // cp 201 <- 200, then cp 100 <- 201, then halt
        mem[4] = 32'd5;
        mem[5] = 32'd201;
        mem[6] = 32'd200;
        mem[8] = 32'd5;
        mem[9] = 32'd100;
        mem[10] = 32'd201;
        mem[12] = 32'd0;
        mem[200] = 32'd1;
        mem[201] = 32'd2;
    endtask

    task automatic run_row(input int index);
        @(negedge clock);
        reset = 1'b1;
        load_program(rows[index]);
        repeat (reset_loops) @(negedge clock);
        reset = 1'b0;
        do @(negedge clock); while (!halted);
        compare_word($sformatf("row %0d mem[check]", index),
                     mem[addr_t'(rows[index].check_addr)], rows[index].result);
        compare_word($sformatf("row %0d mem[100]", index), mem[100], rows[index].cell100);
        compare_word($sformatf("row %0d write_count", index),
                     word_t'(write_count), rows[index].writes);
    endtask

    initial begin
        reset = 1'b1;
        write_count = 0;
        rows[0]  = data_row(32'd1, 32'd5, 32'd7, 32'd12);
        rows[1]  = data_row(32'd1, 32'hffff_ffff, 32'd2, 32'd1);
        rows[2]  = data_row(32'd2, 32'd10, 32'd3, 32'd7);
        rows[3]  = data_row(32'd2, 32'd3, 32'd5, 32'hffff_fffe);
        rows[4]  = data_row(32'd6, 32'hf0f0_ff00, 32'h0ff0_0ff0, 32'h00f0_0f00);
        rows[5]  = data_row(32'd7, 32'hf0f0_0000, 32'h0000_0f0f, 32'hf0f0_0f0f);
        rows[6]  = data_row(32'd8, 32'h1234_5678, 32'd0, 32'hedcb_a987);
        rows[7]  = data_row(32'd5, 32'h5a5a_a5a5, 32'd0, 32'h5a5a_a5a5);
        rows[8]  = branch_row(32'd13, 32'd7, 32'd7, 1'b1);
        rows[9]  = branch_row(32'd13, 32'd7, 32'd8, 1'b0);
        rows[10] = branch_row(32'd14, 32'd7, 32'd8, 1'b1);
        rows[11] = branch_row(32'd14, 32'd9, 32'd9, 1'b0);
        rows[12] = branch_row(32'd15, 32'hffff_fffe, 32'd3, 1'b1);
        rows[13] = branch_row(32'd15, 32'd3, 32'hffff_fffe, 1'b0);
        rows[14] = branch_row(32'd15, 32'hffff_fff0, 32'hffff_fffe, 1'b1);
        // mult is not supported, so the core halts with nothing written
        rows[15] = '{32'd3, 32'd40, 32'd41, 32'd42, 32'd6, 32'd7, 32'd40, 32'd0, 32'd0, 32'd0};
        rows[16] = '{32'd0, 32'd40, 32'd41, 32'd42, 32'd6, 32'd7, 32'd40, 32'd0, 32'd0, 32'd0};
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(watchdog_ns * 1ns);
        $display("watchdog expired before all rows reached halt");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: src.f
+incdir+common
common/e100_pkg.sv
rtl/e100_iar.sv
rtl/e100_datapath.sv
rtl/e100_alu.sv
control/e100_control.sv
rtl/e100_core.sv
tb/e100_asserts.sv
tb/e100_tb.sv

// File: Bender.yml
package:
  name: e100

export_include_dirs:
  - common

sources:
  - common/e100_pkg.sv
  - rtl/e100_iar.sv
  - rtl/e100_datapath.sv
  - rtl/e100_alu.sv
  - control/e100_control.sv
  - rtl/e100_core.sv
  - target: test
    files:
      - tb/e100_asserts.sv
      - tb/e100_tb.sv
